/* Bender.yml */
package:
  name: lab_demo

sources:
  - source/lab_pkg.sv
  - source/tick_timer.sv
  - source/count_display.sv
  - source/alu_4bit.sv
  - source/barrel_shifter.sv
  - source/code_convert.sv
  - source/seq_detector.sv
  - source/lab_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/lab_checker.sv
      - verif/lab_tb.sv

/* files.f */
source/lab_pkg.sv
source/tick_timer.sv
source/count_display.sv
source/alu_4bit.sv
source/barrel_shifter.sv
source/code_convert.sv
source/seq_detector.sv
source/lab_top.sv
verif/tb_clock.sv
verif/lab_checker.sv
verif/lab_tb.sv

/* source/alu_4bit.sv */
`default_nettype none

module alu_4bit (
	input  lab_pkg::alu_op_e            op,
	input  logic [lab_pkg::DATA_W-1:0] a,
	input  logic [lab_pkg::DATA_W-1:0] b,
	output logic [lab_pkg::DATA_W-1:0] result,
	output logic                       zero,
	output logic                       carry,
	output logic                       overflow
);

	import lab_pkg::*;

	localparam int MSB = DATA_W - 1;

	logic [DATA_W:0] sum;  // one extra bit for carry out

	always_comb begin
		sum      = '0;
		result   = '0;
		carry    = 1'b0;
		overflow = 1'b0;
		case (op)
			ADD: begin
				sum      = {1'b0, a} + {1'b0, b};
				result   = sum[MSB:0];
				carry    = sum[DATA_W];
				overflow = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
			end
			SUB: begin
				// a + ~b + 1, carry high means no borrow
				sum      = {1'b0, a} + {1'b0, ~b} + 1'b1;
				result   = sum[MSB:0];
				carry    = sum[DATA_W];
				overflow = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
			end
			NOT_A: result = ~a;
			AND:   result = a & b;
			OR:    result = a | b;
			XOR:   result = a ^ b;
			LESS: begin
				result = {{(DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};
			end
			EQUAL: begin
				result = {{(DATA_W-1){1'b0}}, (a == b)};
			end
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* source/barrel_shifter.sv */
`default_nettype none

module barrel_shifter (
	input  logic [lab_pkg::SHIFT_W-1:0]         data,
	input  logic [$clog2(lab_pkg::SHIFT_W)-1:0] shamt,
	input  logic                                dir_left,
	input  logic                                arith,
	output logic [lab_pkg::SHIFT_W-1:0]         result
);

	import lab_pkg::*;

	localparam int STAGES = $clog2(SHIFT_W);

	logic [SHIFT_W-1:0] stage [0:STAGES];
	logic               fill;

	assign fill     = arith & data[SHIFT_W-1];  // sign fill for right shifts only
	assign stage[0] = data;

	// stage i moves the word by 2**i when shamt[i] is set
	for (genvar i = 0; i < STAGES; i++) begin : g_stage
		localparam int S = 1 << i;

		logic [SHIFT_W-1:0] left_w;
		logic [SHIFT_W-1:0] right_w;

		assign left_w  = {stage[i][SHIFT_W-1-S:0], {S{1'b0}}};
		assign right_w = {{S{fill}}, stage[i][SHIFT_W-1:S]};

		assign stage[i+1] = !shamt[i] ? stage[i] :
		                    dir_left  ? left_w   : right_w;
	end

	assign result = stage[STAGES];

endmodule

`default_nettype wire

/* source/code_convert.sv */
`default_nettype none

module code_convert (
	input  logic [7:0] enc_in,
	input  logic       enc_en,
	output logic [2:0] enc_out,
	output logic       enc_valid,
	input  logic [2:0] dec_in,
	input  logic       dec_en,
	output logic [7:0] dec_out
);

	// ####################
	// 8-to-3 priority encoder

	always_comb begin
		enc_out   = 3'd0;
		enc_valid = 1'b0;
		if (enc_en) begin
			// ascending scan, so the highest set bit wins
			for (int i = 0; i < 8; i++) begin
				if (enc_in[i]) begin
					enc_out   = 3'(i);
					enc_valid = 1'b1;
				end
			end
		end
	end

	// ####################
	// 3-to-8 decoder

	always_comb begin
		if (dec_en)
			dec_out = 8'd1 << dec_in;
		else
			dec_out = 8'd0;
	end

endmodule

`default_nettype wire

/* source/count_display.sv */
`default_nettype none

module count_display (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tick,
	input  logic       count_en,
	output logic [6:0] count,
	output logic [6:0] seg_ones,
	output logic [6:0] seg_tens
);

	import lab_pkg::*;

	logic [3:0] tens;
	logic [3:0] ones;

	// active low, common anode, bit order gfedcba
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		logic [6:0] pat;
		case (digit)
			4'd0:    pat = 7'b1000000;
			4'd1:    pat = 7'b1111001;
			4'd2:    pat = 7'b0100100;
			4'd3:    pat = 7'b0110000;
			4'd4:    pat = 7'b0011001;
			4'd5:    pat = 7'b0010010;
			4'd6:    pat = 7'b0000010;
			4'd7:    pat = 7'b1111000;
			4'd8:    pat = 7'b0000000;
			4'd9:    pat = 7'b0010000;
			default: pat = 7'b1111111;  // blank
		endcase
		return pat;
	endfunction

	// ####################
	// counter

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (tick && count_en) begin
			if (count == count_max)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	// ####################
	// digit split and decode

	always_comb begin
		tens = 4'(count / 7'd10);
		ones = 4'(count % 7'd10);
	end

	assign seg_ones = seg7(ones);
	assign seg_tens = seg7(tens);

endmodule

`default_nettype wire

/* source/lab_pkg.sv */
`default_nettype none

package lab_pkg;

	// ####################
	// ALU

	// function select, same order as the board switches
	typedef enum logic [2:0] {
		ADD   = 3'd0,
		SUB   = 3'd1,
		NOT_A = 3'd2,
		AND   = 3'd3,
		OR    = 3'd4,
		XOR   = 3'd5,
		LESS  = 3'd6,  // signed a < b
		EQUAL = 3'd7
	} alu_op_e;

	localparam int DATA_W = 4;

	// ####################
	// shifter and detector

	localparam int SHIFT_W = 32;

	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		GOT_1   = 3'd1,
		GOT_10  = 3'd2,
		GOT_101 = 3'd3,
		FOUND   = 3'd4  // 1011 seen
	} det_state_e;

	// ####################
	// seconds counter

	localparam int unsigned TICK_DIV_DEFAULT = 50_000_000;  // 1 s at 50 MHz
	localparam logic [6:0] count_max = 7'd99;

endpackage

`default_nettype wire

/* source/lab_top.sv */
`default_nettype none

module lab_top #(
	parameter int unsigned TICK_DIV = lab_pkg::TICK_DIV_DEFAULT
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                count_en,
	input  lab_pkg::alu_op_e                    alu_op,
	input  logic [lab_pkg::DATA_W-1:0]          alu_a,
	input  logic [lab_pkg::DATA_W-1:0]          alu_b,
	input  logic [lab_pkg::SHIFT_W-1:0]         sh_data,
	input  logic [$clog2(lab_pkg::SHIFT_W)-1:0] sh_amt,
	input  logic                                sh_left,
	input  logic                                sh_arith,
	input  logic [7:0]                          enc_in,
	input  logic                                enc_en,
	input  logic [2:0]                          dec_in,
	input  logic                                dec_en,
	input  logic                                din,
	output logic [lab_pkg::DATA_W-1:0]          alu_result,
	output logic                                alu_zero,
	output logic                                alu_carry,
	output logic                                alu_overflow,
	output logic [lab_pkg::SHIFT_W-1:0]         sh_result,
	output logic [2:0]                          enc_out,
	output logic                                enc_valid,
	output logic [7:0]                          dec_out,
	output logic                                found,
	output logic [6:0]                          count,
	output logic [6:0]                          seg_ones,
	output logic [6:0]                          seg_tens
);

	logic tick;  // one cycle every TICK_DIV clocks

	// ####################
	// seconds counter

	tick_timer #(.TICK_DIV(TICK_DIV)) u_tick_timer (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	count_display u_count_display (
		.clk      (clk),
		.rst_n    (rst_n),
		.tick     (tick),
		.count_en (count_en),
		.count    (count),
		.seg_ones (seg_ones),
		.seg_tens (seg_tens)
	);

	// ####################
	// combinational blocks

	alu_4bit u_alu (
		.op       (alu_op),
		.a        (alu_a),
		.b        (alu_b),
		.result   (alu_result),
		.zero     (alu_zero),
		.carry    (alu_carry),
		.overflow (alu_overflow)
	);

	barrel_shifter u_shifter (
		.data     (sh_data),
		.shamt    (sh_amt),
		.dir_left (sh_left),
		.arith    (sh_arith),
		.result   (sh_result)
	);

	code_convert u_code_convert (
		.enc_in    (enc_in),
		.enc_en    (enc_en),
		.enc_out   (enc_out),
		.enc_valid (enc_valid),
		.dec_in    (dec_in),
		.dec_en    (dec_en),
		.dec_out   (dec_out)
	);

	seq_detector u_seq_detector (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (din),
		.found (found)
	);

endmodule

`default_nettype wire

/* source/seq_detector.sv */
`default_nettype none

module seq_detector (
	input  logic clk,
	input  logic rst_n,
	input  logic din,
	output logic found
);

	import lab_pkg::*;

	det_state_e state;
	det_state_e state_nxt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// each state names the longest suffix that is a prefix of 1011
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    state_nxt = din ? GOT_1 : IDLE;
			GOT_1:   state_nxt = din ? GOT_1 : GOT_10;
			GOT_10:  state_nxt = din ? GOT_101 : IDLE;
			GOT_101: state_nxt = din ? FOUND : GOT_10;  // 1010 still ends in 10
			FOUND:   state_nxt = din ? GOT_1 : GOT_10;  // overlap on trailing 1
			default: state_nxt = IDLE;
		endcase
	end

	assign found = (state == FOUND);  // moore output

endmodule

`default_nettype wire

/* source/tick_timer.sv */
`default_nettype none

module tick_timer #(
	parameter int unsigned TICK_DIV = lab_pkg::TICK_DIV_DEFAULT
) (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(TICK_DIV - 1);

	logic [CNT_W-1:0] cnt;

	// reload at the last count and pulse tick on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else if (cnt == LAST) begin
			cnt  <= '0;
			tick <= 1'b1;
		end else begin
			cnt  <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verif/lab_checker.sv */
`default_nettype none

module lab_checker (
	input logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	import lab_pkg::*;

	localparam int TICKS = 105;  // 840 cycles at a period of 8

	event  post;
	string cur_name;
	int    cur_kind;
	int    done_cnt = 0;
	int    pass_cnt = 0;
	int    fail_cnt = 0;
	logic [3:0] hist = '0;  // last four serial bits

	function automatic logic [6:0] seg_of(input int d);
		case (d)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	// {result, zero, carry, overflow}
	function automatic logic [6:0] alu_model(input alu_op_e op, input logic [3:0] a, b);
		int sa;
		int sb;
		int r;
		logic [3:0] res;
		logic c;
		logic v;
		sa = $signed(a);
		sb = $signed(b);
		c = 1'b0;
		v = 1'b0;
		case (op)
			ADD: begin
				r = a + b;
				res = r[3:0];
				c = (r >= 16);
				v = (sa + sb > 7) || (sa + sb < -8);
			end
			SUB: begin
				r = a + 16 - b;  // carry set when there is no borrow
				res = r[3:0];
				c = (r >= 16);
				v = (sa - sb > 7) || (sa - sb < -8);
			end
			NOT_A: res = ~a;
			AND:   res = a & b;
			OR:    res = a | b;
			XOR:   res = a ^ b;
			LESS:  res = (sa < sb) ? 4'd1 : 4'd0;
			default: res = (a == b) ? 4'd1 : 4'd0;
		endcase
		return {res, (res == 4'd0), c, v};
	endfunction

	function automatic logic [31:0] shift_model(input logic [31:0] d, input int amt,
			input logic left, arith);
		if (left)
			return d << amt;
		else if (arith)
			return $signed(d) >>> amt;
		return d >> amt;
	endfunction

	task automatic compare(input logic [63:0] exp, act);
		if (exp === act) begin
			pass_cnt++;
			$display("ok    %s", cur_name);
		end else begin
			fail_cnt++;
			$display("Error %s: expected %h, actual %h", cur_name, exp, act);
		end
	endtask

	task automatic report_counts();
		$display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
	endtask

	// ####################
	// one handler per posted entry

	always @(post) begin
		int start;
		int prev;
		int steps;
		int wraps;
		int bad;
		int exp_cnt;
		logic [2:0] e_out;
		logic e_vld;
		logic [7:0] d_exp;
		case (cur_kind)
			0: begin
				@(posedge clk);  // half a cycle after the drive
				compare(alu_model(lab_tb.alu_op, lab_tb.alu_a, lab_tb.alu_b),
					{lab_tb.alu_result, lab_tb.alu_zero, lab_tb.alu_carry, lab_tb.alu_overflow});
			end
			1: begin
				@(posedge clk);
				compare(shift_model(lab_tb.sh_data, lab_tb.sh_amt, lab_tb.sh_left,
					lab_tb.sh_arith), lab_tb.sh_result);
			end
			2: begin
				e_out = 3'd0;
				e_vld = 1'b0;
				for (int i = 7; i >= 0; i--) begin
					if (lab_tb.enc_en && lab_tb.enc_in[i] && !e_vld) begin
						e_out = 3'(i);
						e_vld = 1'b1;
					end
				end
				@(posedge clk);
				compare({e_out, e_vld}, {lab_tb.enc_out, lab_tb.enc_valid});
			end
			3: begin
				// one-hot at the selected line, all low when disabled
				for (int j = 0; j < 8; j++)
					d_exp[j] = lab_tb.dec_en && (lab_tb.dec_in == j);
				@(posedge clk);
				compare(d_exp, lab_tb.dec_out);
			end
			4: begin
				hist = {hist[2:0], lab_tb.din};
				@(posedge clk);
				#1;  // found settles after the sampling edge
				compare(hist == 4'b1011, lab_tb.found);
			end
			default: begin
				start = lab_tb.count;
				if (lab_tb.count_en) begin
					prev  = start;
					steps = 0;
					wraps = 0;
					bad   = 0;
					for (int n = 0; n < TICKS * 8; n++) begin
						@(negedge clk);
						if (lab_tb.count != prev) begin
							if (prev == count_max && lab_tb.count == 0)
								wraps++;
							else if (lab_tb.count != prev + 1)
								bad++;
							steps++;
							prev = lab_tb.count;
						end
					end
					exp_cnt = (start + TICKS) % (count_max + 1);
					compare({8'(TICKS), 4'((start + TICKS) / (count_max + 1)), 4'd0,
						7'(exp_cnt), seg_of(exp_cnt / 10), seg_of(exp_cnt % 10)},
						{8'(steps), 4'(wraps), 4'(bad),
						lab_tb.count, lab_tb.seg_tens, lab_tb.seg_ones});
				end else begin
					repeat (40) @(negedge clk);
					compare(start, lab_tb.count);  // disabled counter holds
				end
			end
		endcase
		done_cnt++;
	end

endmodule

`default_nettype wire

/* verif/lab_tb.sv */
`default_nettype none

module lab_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import lab_pkg::*;

	localparam int K_ALU = 0, K_SHIFT = 1, K_ENC = 2, K_DEC = 3, K_SER = 4, K_CNT = 5;
	localparam int WAIT_LIMIT = 12000;  // in ns, covers the 840-cycle count test

	logic clk, rst_n, count_en, din;
	alu_op_e alu_op;
	logic [3:0] alu_a, alu_b, alu_result;
	logic alu_zero, alu_carry, alu_overflow;
	logic [31:0] sh_data, sh_result;
	logic [4:0] sh_amt;
	logic sh_left, sh_arith, enc_en, enc_valid, dec_en, found;
	logic [7:0] enc_in, dec_out;
	logic [2:0] dec_in, enc_out;
	logic [6:0] count, seg_ones, seg_tens;

	string t_name[$];
	int    t_kind[$];
	logic [31:0] t_a[$], t_b[$], t_c[$], t_d[$];
	logic [31:0] lcg_state = 32'hb2c01614;
	logic  timed_out = 1'b0;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));
	lab_top #(.TICK_DIV(8)) DUT (.*);
	lab_checker chk (.clk(clk));

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic add_entry(input string name, input int kind,
			input logic [31:0] a, b = 0, c = 0, d = 0);
		t_name.push_back(name);
		t_kind.push_back(kind);
		t_a.push_back(a);
		t_b.push_back(b);
		t_c.push_back(c);
		t_d.push_back(d);
	endtask

	task automatic build_table();
		logic [31:0] r;
		logic [31:0] bits;
		bits = 32'b101101101011;  // 1011011 0 1011, first bit at the left
		// ####################
		add_entry("alu_add_ovf", K_ALU, ADD, 4'h7, 4'h1);
		add_entry("alu_add_carry", K_ALU, ADD, 4'hf, 4'h1);
		add_entry("alu_sub_borrow", K_ALU, SUB, 4'h3, 4'h5);
		add_entry("alu_sub_ovf", K_ALU, SUB, 4'h8, 4'h1);
		add_entry("alu_not", K_ALU, NOT_A, 4'ha, 4'h0);
		add_entry("alu_and", K_ALU, AND, 4'hc, 4'ha);
		add_entry("alu_or", K_ALU, OR, 4'hc, 4'ha);
		add_entry("alu_xor_zero", K_ALU, XOR, 4'h5, 4'h5);
		add_entry("alu_less_signed", K_ALU, LESS, 4'h8, 4'h1);
		add_entry("alu_equal", K_ALU, EQUAL, 4'h9, 4'h9);
		for (int i = 0; i < 8; i++) begin
			r = lcg_next();
			add_entry($sformatf("alu_rand_%0d", i), K_ALU, r[18:16], r[11:8], r[27:24]);
		end
		// ####################
		add_entry("shl_0", K_SHIFT, 32'h8000_0001, 0, 1, 0);
		add_entry("shl_31", K_SHIFT, 32'h0000_0003, 31, 1, 1);
		add_entry("shr_log_31", K_SHIFT, 32'h8000_0000, 31, 0, 0);
		add_entry("shr_ari_31", K_SHIFT, 32'h8000_0000, 31, 0, 1);
		add_entry("shr_ari_4", K_SHIFT, 32'hf0f0_1234, 4, 0, 1);
		add_entry("shr_ari_pos", K_SHIFT, 32'h7000_0000, 8, 0, 1);
		for (int i = 0; i < 4; i++) begin
			r = lcg_next();
			add_entry($sformatf("shift_rand_%0d", i), K_SHIFT, lcg_next(), r[4:0], r[8], r[12]);
		end
		// ####################
		add_entry("enc_onehot", K_ENC, 8'h10, 1);
		add_entry("enc_multi", K_ENC, 8'h29, 1);
		add_entry("enc_zero", K_ENC, 8'h00, 1);
		add_entry("enc_disabled", K_ENC, 8'h80, 0);
		for (int i = 0; i < 8; i++)
			add_entry($sformatf("dec_%0d", i), K_DEC, i, 1);
		add_entry("dec_disabled", K_DEC, 5, 0);
		for (int i = 0; i < 12; i++)
			add_entry($sformatf("serial_bit_%0d", i + 1), K_SER, bits[11-i]);
		add_entry("count_run", K_CNT, 1);
		add_entry("count_hold", K_CNT, 0);
	endtask

	task automatic apply_entry(input int i);
		case (t_kind[i])
			K_ALU: begin
				alu_op = alu_op_e'(t_a[i][2:0]);
				alu_a  = t_b[i][3:0];
				alu_b  = t_c[i][3:0];
			end
			K_SHIFT: begin
				sh_data  = t_a[i];
				sh_amt   = t_b[i][4:0];
				sh_left  = t_c[i][0];
				sh_arith = t_d[i][0];
			end
			K_ENC: {enc_in, enc_en} = {t_a[i][7:0], t_b[i][0]};
			K_DEC: {dec_in, dec_en} = {t_a[i][2:0], t_b[i][0]};
			K_SER: din = t_a[i][0];
			default: count_en = t_a[i][0];
		endcase
	endtask

	initial begin
		int n;
		int target;
		{count_en, din, sh_left, sh_arith, enc_en, dec_en} = '0;
		alu_op  = ADD;
		{alu_a, alu_b, sh_amt, enc_in, dec_in} = '0;
		sh_data = '0;
		build_table();
		for (n = 0; rst_n !== 1'b1 && n < 20; n++)
			@(posedge clk);
		if (rst_n !== 1'b1) begin
			$display("reset was never released");
			timed_out = 1'b1;
		end
		for (int i = 0; i < t_name.size() && !timed_out; i++) begin
			@(negedge clk);
			apply_entry(i);
			chk.cur_name = t_name[i];
			chk.cur_kind = t_kind[i];
			target = chk.done_cnt + 1;
			-> chk.post;
			for (n = 0; chk.done_cnt < target && n < WAIT_LIMIT; n++)
				#1;
			if (chk.done_cnt < target) begin
				$display("checker gave no result for test %s", t_name[i]);
				timed_out = 1'b1;
			end
		end
		chk.report_counts();
		if (!timed_out && chk.fail_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

	initial begin
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire
